/* rtl/dram_pkg.sv */
// dram port shared definitions
`default_nettype none

package dram_pkg;

   // data and byte address width
   localparam int word_w = 32;

   // byte lanes per word
   localparam int mask_w = 4;

   // load/store size, same values as the rv32 funct3 low bits
   typedef enum logic [1:0] {
      acc_byte = 2'd0,
      acc_half = 2'd1,
      acc_word = 2'd2
   } access_size_e;

   // funct3 of a load or store
   typedef struct packed {
      logic         is_unsigned; // lbu/lhu, zero extend
      access_size_e size;
   } access_ctrl_t;

endpackage

`default_nettype wire

/* rtl/mem_word_if.sv */
// word command bus
`timescale 1ns/10ps
`default_nettype none

interface mem_word_if #(
   parameter int addr_w = 10
);
   import dram_pkg::*;

   // one-cycle command pulses, at most one at a time
   logic              rd;
   logic              we;
   logic              refresh;

   logic [addr_w-1:0] addr;  // word index
   logic [word_w-1:0] wdata;
   logic [mask_w-1:0] mask;  // 1 = lane written

   logic [word_w-1:0] rdata; // valid once busy drops after a read
   logic              busy;

   // access unit side
   modport master (
      output rd, we, refresh, addr, wdata, mask,
      input  rdata, busy
   );

   // word controller side
   modport slave (
      input  rd, we, refresh, addr, wdata, mask,
      output rdata, busy
   );

endinterface

`default_nettype wire

/* rtl/refresh_timer.sv */
// refresh interval timer
`timescale 1ns/10ps
`default_nettype none

module refresh_timer #(
   parameter int refresh_interval = 64,
   parameter int refresh_limit    = 128
) (
   input  wire logic clk,
   input  wire logic rst_x,
   input  wire logic i_refresh_grant,
   output logic      o_refresh_req,
   output logic      o_late_refresh
);

   localparam int cnt_w = $clog2(refresh_limit + 1);

   logic [cnt_w-1:0] cnt;
   logic             at_limit;

   assign at_limit = (cnt == cnt_w'(refresh_limit));

   // counts cycles since the last refresh, stops at the limit
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         cnt <= '0;
      end else if (i_refresh_grant) begin
         cnt <= '0;
      end else if (!at_limit) begin
         cnt <= cnt + 1'b1;
      end
   end

   // held until granted
   assign o_refresh_req = (cnt >= cnt_w'(refresh_interval));

   // sticky, only reset clears it
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         o_late_refresh <= 1'b0;
      end else if (at_limit) begin
         o_late_refresh <= 1'b1;
      end
   end

   a_grant_req : assert property (@(posedge clk) disable iff (!rst_x)
      i_refresh_grant |-> o_refresh_req)
      else $error("refresh granted without a request");

endmodule

`default_nettype wire

/* rtl/dram_access_unit.sv */
// load/store access unit
`timescale 1ns/10ps
`default_nettype none

module dram_access_unit #(
   parameter int mem_words = 1024
) (
   input  wire logic                      clk,
   input  wire logic                      rst_x,
   input  wire logic                      i_rd_en,
   input  wire logic                      i_wr_en,
   input  wire logic [dram_pkg::word_w-1:0] i_addr,
   input  wire logic [dram_pkg::word_w-1:0] i_data,
   input  wire dram_pkg::access_ctrl_t    i_ctrl,
   output logic      [dram_pkg::word_w-1:0] o_data,
   output logic                           o_busy,
   input  wire logic                      i_refresh_req,
   output logic                           o_refresh_grant,
   mem_word_if.master                     m_bus
);
   import dram_pkg::*;

   localparam int addr_w = $clog2(mem_words);

   typedef enum logic [2:0] {
      s_idle,
      s_cmd1,  // first word command
      s_wait1,
      s_next,  // step to the following word
      s_cmd2,
      s_wait2,
      s_done
   } state_e;

   state_e state;

   logic                r_is_rd;
   logic [1:0]          r_off;   // byte offset in the word
   logic [addr_w-1:0]   r_word;
   access_ctrl_t        r_ctrl;
   logic [word_w-1:0]   r_data;
   logic [word_w-1:0]   r_data1; // first word read
   logic [word_w-9:0]   r_data2; // at most 3 bytes of the second word matter

   logic                accept;
   logic                ref_go;
   logic                split;

   logic [mask_w-1:0]   size_mask;
   logic [word_w-1:0]   st_data;
   logic [2*word_w-1:0] st_wide;
   logic [2*mask_w-1:0] st_mask;
   logic [2*word_w-9:0] ld_join;
   logic [word_w-1:0]   ld_ext;

   assign accept = (state == s_idle) && (i_rd_en || i_wr_en) && !m_bus.busy;

   // refresh only when nothing is asked for
   assign ref_go = (state == s_idle) && i_refresh_req && !i_rd_en && !i_wr_en
                   && !m_bus.busy;
   assign o_refresh_grant = ref_go;

   // lanes of the access before placement
   always_comb begin
      case (r_ctrl.size)
         acc_byte: begin
            size_mask = 4'b0001;
            st_data   = {{(word_w-8){1'b0}}, r_data[7:0]};
         end
         acc_half: begin
            size_mask = 4'b0011;
            st_data   = {{(word_w-16){1'b0}}, r_data[15:0]};
         end
         default: begin
            size_mask = 4'b1111;
            st_data   = r_data;
         end
      endcase
   end

   // low half goes to the first word, high half spills into the next one
   assign st_wide = {{word_w{1'b0}}, st_data} << {r_off, 3'b000};
   assign st_mask = {{mask_w{1'b0}}, size_mask} << r_off;
   assign split   = |st_mask[2*mask_w-1:mask_w];

   // both words joined, then shifted down to the addressed byte
   assign ld_join = {r_data2, r_data1} >> {r_off, 3'b000};

   always_comb begin
      case (r_ctrl.size)
         acc_byte:
            ld_ext = r_ctrl.is_unsigned ? {{(word_w-8){1'b0}}, ld_join[7:0]}
                                        : {{(word_w-8){ld_join[7]}}, ld_join[7:0]};
         acc_half:
            ld_ext = r_ctrl.is_unsigned ? {{(word_w-16){1'b0}}, ld_join[15:0]}
                                        : {{(word_w-16){ld_join[15]}}, ld_join[15:0]};
         default:
            ld_ext = ld_join[word_w-1:0];
      endcase
   end

   // word commands
   assign m_bus.rd      = ((state == s_cmd1) || (state == s_cmd2)) && r_is_rd;
   assign m_bus.we      = ((state == s_cmd1) || (state == s_cmd2)) && !r_is_rd;
   assign m_bus.refresh = ref_go;
   assign m_bus.addr    = r_word;
   assign m_bus.wdata   = (state == s_cmd2) ? st_wide[2*word_w-1:word_w]
                                            : st_wide[word_w-1:0];
   assign m_bus.mask    = (state == s_cmd2) ? st_mask[2*mask_w-1:mask_w]
                                            : st_mask[mask_w-1:0];

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         state   <= s_idle;
         o_busy  <= 1'b0;
         r_is_rd <= 1'b0;
         o_data  <= '0;
      end else begin
         case (state)
            s_idle: begin
               if (accept) begin
                  state   <= s_cmd1;
                  o_busy  <= 1'b1;
                  r_is_rd <= i_rd_en; // read wins
               end
            end
            s_cmd1:  state <= s_wait1;
            s_wait1: begin
               if (!m_bus.busy) begin
                  state <= split ? s_next : s_done;
               end
            end
            s_next:  state <= s_cmd2;
            s_cmd2:  state <= s_wait2;
            s_wait2: begin
               if (!m_bus.busy) begin
                  state <= s_done;
               end
            end
            s_done: begin
               state  <= s_idle;
               o_busy <= 1'b0;
               if (r_is_rd) begin
                  o_data <= ld_ext; // held until the next read
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   // request capture and read data
   always_ff @(posedge clk) begin
      if (accept) begin
         r_off  <= i_addr[1:0];
         r_word <= i_addr[2 +: addr_w];
         r_ctrl <= i_ctrl;
         r_data <= i_data;
      end else if (state == s_next) begin
         r_word <= r_word + 1'b1;
      end
      if ((state == s_wait1) && !m_bus.busy && r_is_rd) begin
         r_data1 <= m_bus.rdata;
      end
      if ((state == s_wait2) && !m_bus.busy && r_is_rd) begin
         r_data2 <= m_bus.rdata[word_w-9:0];
      end
   end

   a_cmd_idle : assert property (@(posedge clk) disable iff (!rst_x)
      (m_bus.rd || m_bus.we || m_bus.refresh) |-> !m_bus.busy)
      else $error("word command issued while controller busy");

endmodule

`default_nettype wire

/* rtl/mem_word_ctrl.sv */
// word memory controller model
`timescale 1ns/10ps
`default_nettype none

module mem_word_ctrl #(
   parameter int mem_words = 1024,
   parameter int latency   = 4
) (
   input  wire logic clk,
   input  wire logic rst_x,
   mem_word_if.slave s_bus
);
   import dram_pkg::*;

   localparam int addr_w = $clog2(mem_words);
   localparam int cnt_w  = $clog2(2 * latency + 1);

   logic [word_w-1:0] mem [mem_words];

   logic [cnt_w-1:0]  busy_cnt; // cycles left in the current command
   logic              rd_pend;
   logic [addr_w-1:0] rd_addr;
   logic              cmd;
   logic              last;

   assign cmd  = s_bus.rd || s_bus.we || s_bus.refresh;
   assign last = (busy_cnt == cnt_w'(1));

   assign s_bus.busy = (busy_cnt != '0);

   // refresh holds the controller twice as long
   always_ff @(posedge clk) begin
      if (!rst_x) begin
         busy_cnt <= '0;
         rd_pend  <= 1'b0;
      end else if (cmd && !s_bus.busy) begin
         busy_cnt <= s_bus.refresh ? cnt_w'(2 * latency) : cnt_w'(latency);
         rd_pend  <= s_bus.rd;
      end else if (s_bus.busy) begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   // array and read data path
   always_ff @(posedge clk) begin
      if (s_bus.we && !s_bus.busy) begin
         for (int i = 0; i < mask_w; i++) begin
            if (s_bus.mask[i]) begin
               mem[s_bus.addr][8*i +: 8] <= s_bus.wdata[8*i +: 8];
            end
         end
      end
      if (s_bus.rd && !s_bus.busy) begin
         rd_addr <= s_bus.addr;
      end
      if (rd_pend && last) begin
         s_bus.rdata <= mem[rd_addr]; // lands as busy drops
      end
   end

   a_cmd_busy : assert property (@(posedge clk) disable iff (!rst_x)
      cmd |-> !s_bus.busy ##1 s_bus.busy)
      else $error("word command arrived while busy");

endmodule

`default_nettype wire

/* rtl/dram_subsys.sv */
// dram load/store subsystem top
`timescale 1ns/10ps
`default_nettype none

module dram_subsys #(
   parameter int mem_words        = 1024,
   parameter int latency          = 4,
   parameter int refresh_interval = 64,
   parameter int refresh_limit    = 128
) (
   input  wire logic                        clk,
   input  wire logic                        rst_x,
   input  wire logic                        i_rd_en,
   input  wire logic                        i_wr_en,
   input  wire logic [dram_pkg::word_w-1:0] i_addr,
   input  wire logic [dram_pkg::word_w-1:0] i_data,
   input  wire dram_pkg::access_ctrl_t      i_ctrl,
   output logic      [dram_pkg::word_w-1:0] o_data,
   output logic                             o_busy,
   output logic                             o_late_refresh
);

   logic refresh_req;
   logic refresh_grant;

   mem_word_if #(.addr_w($clog2(mem_words))) mem_bus ();

   refresh_timer #(
      .refresh_interval (refresh_interval),
      .refresh_limit    (refresh_limit)
   ) timer_i (
      .clk             (clk),
      .rst_x           (rst_x),
      .i_refresh_grant (refresh_grant),
      .o_refresh_req   (refresh_req),
      .o_late_refresh  (o_late_refresh)
   );

   dram_access_unit #(
      .mem_words (mem_words)
   ) access_i (
      .clk             (clk),
      .rst_x           (rst_x),
      .i_rd_en         (i_rd_en),
      .i_wr_en         (i_wr_en),
      .i_addr          (i_addr),
      .i_data          (i_data),
      .i_ctrl          (i_ctrl),
      .o_data          (o_data),
      .o_busy          (o_busy),
      .i_refresh_req   (refresh_req),
      .o_refresh_grant (refresh_grant),
      .m_bus           (mem_bus.master)
   );

   mem_word_ctrl #(
      .mem_words (mem_words),
      .latency   (latency)
   ) ctrl_i (
      .clk   (clk),
      .rst_x (rst_x),
      .s_bus (mem_bus.slave)
   );

endmodule

`default_nettype wire

/* testbench/tb_clkgen.sv */
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
   output logic o_clk,
   output logic o_rst_x
);

   localparam int half_period = 10; // 20 ns clock

   initial begin
      o_clk = 1'b0;
      forever #(half_period) o_clk = ~o_clk;
   end

   // reset low for the first 10 rising edges
   initial begin
      o_rst_x = 1'b0;
      repeat (10) @(posedge o_clk);
      o_rst_x <= 1'b1;
   end

endmodule

`default_nettype wire

/* testbench/tb_dram_subsys.sv */
// load/store port testbench
`timescale 1ns/10ps
`default_nettype none

module tb_dram_subsys;
   import dram_pkg::*;

   localparam int mem_words        = 1024;
   localparam int latency          = 4;
   localparam int refresh_interval = 64;
   localparam int refresh_limit    = 128;
   localparam int clk_period       = 20;
   localparam int margin_ns        = 4000; // reset and refresh slack
   localparam     stim_file        = "testbench/dram_stim.txt";

   logic              clk;
   logic              rst_x;
   logic              i_rd_en;
   logic              i_wr_en;
   logic [word_w-1:0] i_addr;
   logic [word_w-1:0] i_data;
   access_ctrl_t      i_ctrl;
   logic [word_w-1:0] o_data;
   logic              o_busy;
   logic              o_late_refresh;

   // one entry per access line
   byte               op_q[$];
   logic [2:0]        ctrl_q[$];
   logic [word_w-1:0] addr_q[$];
   logic [word_w-1:0] data_q[$];
   logic [word_w-1:0] exp_q[$];

   int errors;
   int checks;
   bit loaded;

   tb_clkgen clkgen_i (
      .o_clk   (clk),
      .o_rst_x (rst_x)
   );

   dram_subsys #(
      .mem_words        (mem_words),
      .latency          (latency),
      .refresh_interval (refresh_interval),
      .refresh_limit    (refresh_limit)
   ) dram_subsys_i (
      .clk            (clk),
      .rst_x          (rst_x),
      .i_rd_en        (i_rd_en),
      .i_wr_en        (i_wr_en),
      .i_addr         (i_addr),
      .i_data         (i_data),
      .i_ctrl         (i_ctrl),
      .o_data         (o_data),
      .o_busy         (o_busy),
      .o_late_refresh (o_late_refresh)
   );

   task automatic load_stim(output bit ok);
      int                fd;
      int                n;
      byte               op;
      logic [2:0]        ctrl;
      logic [word_w-1:0] addr;
      logic [word_w-1:0] data;
      logic [word_w-1:0] expv;
      logic [8*160-1:0]  skip;
      ok = 1'b0;
      fd = $fopen(stim_file, "r");
      if (fd == 0) begin
         $display("could not open the stimulus file %s", stim_file);
      end else begin
         ok = 1'b1;
         while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", op);
            if (n == 1) begin
               if (op == "#") begin
                  n = $fgets(skip, fd); // comment line
               end else begin
                  n = $fscanf(fd, "%h %h %h %h", ctrl, addr, data, expv);
                  if (n == 4) begin
                     op_q.push_back(op);
                     ctrl_q.push_back(ctrl);
                     addr_q.push_back(addr);
                     data_q.push_back(data);
                     exp_q.push_back(expv);
                  end else begin
                     $display("stimulus line %0d is malformed", op_q.size() + 1);
                     ok = 1'b0;
                  end
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // one access, enable held until taken, checked when o_busy drops
   task automatic run_access(input int idx);
      int busy_cycles;
      int exp_cycles;
      int nbytes;
      bit is_rd;
      is_rd  = (op_q[idx] == "R");
      nbytes = (ctrl_q[idx][1:0] == 2'd0) ? 1 : (ctrl_q[idx][1:0] == 2'd1) ? 2 : 4;
      // two word commands when the access runs past byte 3
      exp_cycles = (addr_q[idx][1:0] + nbytes > 4) ? 2*latency + 6 : latency + 3;
      @(posedge clk);
      i_rd_en <= is_rd;
      i_wr_en <= !is_rd;
      i_addr  <= addr_q[idx];
      i_data  <= data_q[idx];
      i_ctrl  <= ctrl_q[idx];
      @(negedge clk);
      while (!o_busy) @(negedge clk);
      busy_cycles = 1;
      @(posedge clk);
      i_rd_en <= 1'b0;
      i_wr_en <= 1'b0;
      @(negedge clk);
      while (o_busy) begin
         busy_cycles++;
         @(negedge clk);
      end
      checks++;
      if (busy_cycles != exp_cycles) begin
         errors++;
         $display("FAIL %0t: addr %h busy for %0d cycles, expected %0d",
                  $time, addr_q[idx], busy_cycles, exp_cycles);
      end
      if (is_rd) begin
         checks++;
         if (o_data !== exp_q[idx]) begin
            errors++;
            $display("FAIL %0t: addr %h expected %h got %h",
                     $time, addr_q[idx], exp_q[idx], o_data);
         end
      end
   endtask

   initial begin : watchdog
      longint limit_ns;
      wait (loaded);
      limit_ns = longint'(op_q.size()) * (4*latency + 6) * clk_period + margin_ns;
      #(limit_ns);
      $display("watchdog expired, the run did not end within %0d ns", limit_ns);
      $display("Something failed");
      $finish;
   end

   initial begin : main
      bit ok;
      errors  = 0;
      checks  = 0;
      i_rd_en = 1'b0;
      i_wr_en = 1'b0;
      i_addr  = '0;
      i_data  = '0;
      i_ctrl  = '0;
      load_stim(ok);
      loaded = 1'b1;
      if (!ok) begin
         errors++;
      end else begin
         while (rst_x !== 1'b1) @(posedge clk);
         @(negedge clk);
         checks++;
         if (o_busy !== 1'b0 || o_data !== '0 || o_late_refresh !== 1'b0) begin
            errors++;
            $display("FAIL %0t: outputs after reset busy %b data %h late %b",
                     $time, o_busy, o_data, o_late_refresh);
         end
         for (int i = 0; i < op_q.size(); i++) begin
            run_access(i);
         end
         checks++;
         if (o_late_refresh !== 1'b0) begin
            errors++;
            $display("FAIL %0t: late refresh flag set", $time);
         end
      end
      $display("errors: %0d  checks: %0d", errors, checks);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dram_subsys.f */
rtl/dram_pkg.sv
rtl/mem_word_if.sv
rtl/refresh_timer.sv
rtl/dram_access_unit.sv
rtl/mem_word_ctrl.sv
rtl/dram_subsys.sv
testbench/tb_clkgen.sv
testbench/tb_dram_subsys.sv

/* testbench/dram_stim.txt */
# op(W/R) ctrl addr data expected, all hex, expected unused for W
# ctrl = {unsigned, size[1:0]}, size 0 byte, 1 half, 2 word
W 2 00000100 deadbeef 00000000
R 2 00000100 00000000 deadbeef
W 2 00000104 01234567 00000000
R 2 00000104 00000000 01234567
# byte and half stores into one word
W 2 00000200 11223344 00000000
W 0 00000201 000000a5 00000000
W 1 00000202 0000c0de 00000000
R 2 00000200 00000000 c0dea544
# sign and zero extension
R 0 00000201 00000000 ffffffa5
R 4 00000201 00000000 000000a5
R 1 00000202 00000000 ffffc0de
R 5 00000202 00000000 0000c0de
R 0 00000200 00000000 00000044
R 1 00000200 00000000 ffffa544
# accesses across a word boundary
W 2 00000300 aabbccdd 00000000
W 2 00000304 eeff0011 00000000
W 2 00000302 87654321 00000000
R 2 00000302 00000000 87654321
R 2 00000300 00000000 4321ccdd
R 2 00000304 00000000 eeff8765
W 2 00000308 55667788 00000000
W 1 00000307 0000beef 00000000
R 5 00000307 00000000 0000beef
R 1 00000307 00000000 ffffbeef
R 2 00000304 00000000 efff8765
R 2 00000308 00000000 556677be
R 2 00000305 00000000 beefff87
R 2 00000303 00000000 ff876543
# more traffic while refreshes come due
W 2 000003fc 0badf00d 00000000
R 2 000003fc 00000000 0badf00d
W 2 00000ffc 13579bdf 00000000
R 2 00000ffc 00000000 13579bdf
R 2 00000100 00000000 deadbeef
R 2 00000104 00000000 01234567
